// ==== files.f ====
rtl/tl_pkg.sv
rtl/tl_fifo.sv
rtl/tl_credit_counter.sv
rtl/tl_tag_table.sv
rtl/tl_tx_fsm.sv
rtl/tl_top.sv
testbench/tb_tl_top.sv

// ==== rtl/tl_credit_counter.sv ====
// Transmit credit counter
// One credit per TLP, given back one at a time by the link layer
`default_nettype none

module tl_credit_counter (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic consume,
    input  wire logic credit_return,
    output logic      credit_avail
);

    logic [tl_pkg::CREDIT_W-1:0] count;

    // Link layer grants the full pool out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= tl_pkg::CREDIT_W'(tl_pkg::CREDIT_MAX);
        end else begin
            case ({consume, credit_return})
                2'b10: begin
                    count <= count - 1'b1;
                end
                2'b01: begin
                    count <= count + 1'b1;
                end
                default: begin
                    // Both or neither leave the count alone
                    count <= count;
                end
            endcase
        end
    end

    assign credit_avail = (count != '0);

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    a_no_consume_empty : assert property (@(posedge clk) disable iff (!rst_n)
        consume |-> count != '0);

    // Link layer returns no more than it took
    a_no_excess_return : assert property (@(posedge clk) disable iff (!rst_n)
        (credit_return && !consume) |-> count < tl_pkg::CREDIT_W'(tl_pkg::CREDIT_MAX));

    a_count_bounded : assert property (@(posedge clk) disable iff (!rst_n)
        count <= tl_pkg::CREDIT_W'(tl_pkg::CREDIT_MAX));

endmodule

`default_nettype wire

// ==== rtl/tl_fifo.sv ====
// Synchronous FIFO for any packed payload
// Circular buffer whose head shows the oldest entry
`default_nettype none

module tl_fifo #(
    parameter type PAYLOAD_T = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     push,
    input  wire PAYLOAD_T push_data,
    input  wire logic     pop,
    output PAYLOAD_T      head,
    output logic          empty,
    output logic          full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    PAYLOAD_T         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Pointer wrap that also handles depths other than a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full);

    a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== rtl/tl_pkg.sv ====
// Transaction layer package
// Sizing constants, TLP header layout and AXI-side request types
`default_nettype none

package tl_pkg;

    // ----------------------------------------------------------------------
    // Sizing
    // ----------------------------------------------------------------------
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = 4;
    localparam int ID_W       = 4;
    localparam int TAG_W      = 4;
    localparam int TAG_COUNT  = 16;
    localparam int CREDIT_MAX = 8;
    localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);
    localparam int REQ_DEPTH  = 4;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ----------------------------------------------------------------------
    // TLP header
    // ----------------------------------------------------------------------
    typedef enum logic [7:0] {
        TLP_MRD32 = 8'h00,
        TLP_MWR32 = 8'h40,
        TLP_CPLD  = 8'h4A
    } tlp_fmt_type_t;

    typedef enum logic [2:0] {
        CPL_SC = 3'b000,
        CPL_UR = 3'b001
    } cpl_status_t;

    typedef struct packed {
        tlp_fmt_type_t     fmt_type;
        logic [9:0]        length;
        logic [7:0]        tag;
        logic [STRB_W-1:0] first_be;
        cpl_status_t       status;
        logic [ADDR_W-1:0] addr;
    } tlp_hdr_t;

    // One header plus one DW in either direction
    typedef struct packed {
        tlp_hdr_t          hdr;
        logic [DATA_W-1:0] data;
    } tlp_t;

    // ----------------------------------------------------------------------
    // AXI side
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wr_req_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
    } rd_resp_t;

endpackage

`default_nettype wire

// ==== rtl/tl_tag_table.sv ====
// Read tag table
// Hands out tags, keeps the AXI ID per tag and turns completions into read responses
`default_nettype none

module tl_tag_table (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     alloc,
    input  wire logic [tl_pkg::ID_W-1:0]  alloc_id,
    input  wire tl_pkg::tlp_t             cpl_head,
    input  wire logic                     cpl_empty,
    input  wire logic                     rd_resp_ready,
    output logic                          tag_free,
    output logic [tl_pkg::TAG_W-1:0]      alloc_tag,
    output logic                          cpl_pop,
    output logic                          rd_resp_valid,
    output tl_pkg::rd_resp_t              rd_resp
);

    logic [tl_pkg::TAG_COUNT-1:0] busy;
    logic [tl_pkg::ID_W-1:0]      id_mem [tl_pkg::TAG_COUNT];
    logic [tl_pkg::TAG_W-1:0]     cpl_tag;
    logic                         cpl_load;

    // ----------------------------------------------------------------------
    // Allocation
    // ----------------------------------------------------------------------

    // Lowest free tag wins
    always_comb begin
        alloc_tag = '0;
        for (int i = tl_pkg::TAG_COUNT - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                alloc_tag = tl_pkg::TAG_W'(i);
            end
        end
    end

    assign tag_free = ~&busy;

    always_ff @(posedge clk) begin
        if (alloc) begin
            id_mem[alloc_tag] <= alloc_id;
        end
    end

    // ----------------------------------------------------------------------
    // Completion to read response
    // ----------------------------------------------------------------------
    assign cpl_tag  = cpl_head.hdr.tag[tl_pkg::TAG_W-1:0];
    assign cpl_load = !cpl_empty && !rd_resp_valid;

    // Head stays in the queue until the response is taken
    assign cpl_pop  = rd_resp_valid && rd_resp_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy          <= '0;
            rd_resp_valid <= 1'b0;
        end else begin
            if (alloc) begin
                busy[alloc_tag] <= 1'b1;
            end
            if (cpl_pop) begin
                busy[cpl_tag] <= 1'b0;
                rd_resp_valid <= 1'b0;
            end else if (cpl_load) begin
                rd_resp_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpl_load) begin
            rd_resp.id   <= id_mem[cpl_tag];
            rd_resp.data <= cpl_head.data;
            rd_resp.resp <= (cpl_head.hdr.status == tl_pkg::CPL_SC) ?
                            tl_pkg::RESP_OKAY : tl_pkg::RESP_SLVERR;
        end
    end

    // Completion must answer a read that is still outstanding
    a_cpl_tag_busy : assert property (@(posedge clk) disable iff (!rst_n)
        cpl_load |-> busy[cpl_tag]);

    a_cpl_is_cpld : assert property (@(posedge clk) disable iff (!rst_n)
        cpl_load |-> cpl_head.hdr.fmt_type == tl_pkg::TLP_CPLD);

endmodule

`default_nettype wire

// ==== rtl/tl_top.sv ====
// PCIe transaction layer request path
// AXI slave requests to MWr/MRd TLPs, completions back to read responses
`default_nettype none

module tl_top (
    input  wire logic             clk,
    input  wire logic             rst_n,
    // Write requests and responses
    input  wire logic             wr_req_valid,
    output logic                  wr_req_ready,
    input  wire tl_pkg::wr_req_t  wr_req,
    output logic                  wr_resp_valid,
    input  wire logic             wr_resp_ready,
    // Read requests and responses
    input  wire logic             rd_req_valid,
    output logic                  rd_req_ready,
    input  wire tl_pkg::rd_req_t  rd_req,
    output logic                  rd_resp_valid,
    input  wire logic             rd_resp_ready,
    output tl_pkg::rd_resp_t      rd_resp,
    // Link layer
    output logic                  tlp_tx_valid,
    output tl_pkg::tlp_t          tlp_tx,
    input  wire logic             credit_return,
    input  wire logic             cpl_valid,
    input  wire tl_pkg::tlp_t     cpl
);

    tl_pkg::wr_req_t              wr_head;
    tl_pkg::rd_req_t              rd_head;
    tl_pkg::tlp_t                 cpl_head;
    logic                         wr_empty;
    logic                         wr_full;
    logic                         wr_pop;
    logic                         rd_empty;
    logic                         rd_full;
    logic                         rd_pop;
    logic                         cpl_empty;
    logic                         cpl_pop;
    logic                         consume;
    logic                         credit_avail;
    logic                         alloc;
    logic [tl_pkg::ID_W-1:0]      alloc_id;
    logic [tl_pkg::TAG_W-1:0]     alloc_tag;
    logic                         tag_free;

    assign wr_req_ready = !wr_full;
    assign rd_req_ready = !rd_full;

    // ----------------------------------------------------------------------
    // Queues
    // ----------------------------------------------------------------------
    tl_fifo #(.PAYLOAD_T(tl_pkg::wr_req_t), .DEPTH(tl_pkg::REQ_DEPTH)) u_wr_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (wr_req_valid && wr_req_ready),
        .push_data (wr_req),
        .pop       (wr_pop),
        .head      (wr_head),
        .empty     (wr_empty),
        .full      (wr_full)
    );

    tl_fifo #(.PAYLOAD_T(tl_pkg::rd_req_t), .DEPTH(tl_pkg::REQ_DEPTH)) u_rd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rd_req_valid && rd_req_ready),
        .push_data (rd_req),
        .pop       (rd_pop),
        .head      (rd_head),
        .empty     (rd_empty),
        .full      (rd_full)
    );

    // Sized to the tag pool, so completions never see back-pressure
    tl_fifo #(.PAYLOAD_T(tl_pkg::tlp_t), .DEPTH(tl_pkg::TAG_COUNT)) u_cpl_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (cpl_valid),
        .push_data (cpl),
        .pop       (cpl_pop),
        .head      (cpl_head),
        .empty     (cpl_empty),
        .full      ()
    );

    // ----------------------------------------------------------------------
    // Transmit control
    // ----------------------------------------------------------------------
    tl_tx_fsm u_tx_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_head       (wr_head),
        .wr_empty      (wr_empty),
        .rd_head       (rd_head),
        .rd_empty      (rd_empty),
        .credit_avail  (credit_avail),
        .tag_free      (tag_free),
        .alloc_tag     (alloc_tag),
        .wr_resp_ready (wr_resp_ready),
        .wr_pop        (wr_pop),
        .rd_pop        (rd_pop),
        .consume       (consume),
        .alloc         (alloc),
        .alloc_id      (alloc_id),
        .tlp_tx_valid  (tlp_tx_valid),
        .tlp_tx        (tlp_tx),
        .wr_resp_valid (wr_resp_valid)
    );

    tl_credit_counter u_credit_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .consume       (consume),
        .credit_return (credit_return),
        .credit_avail  (credit_avail)
    );

    tl_tag_table u_tag_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc         (alloc),
        .alloc_id      (alloc_id),
        .cpl_head      (cpl_head),
        .cpl_empty     (cpl_empty),
        .rd_resp_ready (rd_resp_ready),
        .tag_free      (tag_free),
        .alloc_tag     (alloc_tag),
        .cpl_pop       (cpl_pop),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp       (rd_resp)
    );

endmodule

`default_nettype wire

// ==== rtl/tl_tx_fsm.sv ====
// Transmit FSM
// Picks queued writes before reads and sends MWr/MRd TLPs under credit and tag limits
`default_nettype none

module tl_tx_fsm (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire tl_pkg::wr_req_t         wr_head,
    input  wire logic                    wr_empty,
    input  wire tl_pkg::rd_req_t         rd_head,
    input  wire logic                    rd_empty,
    input  wire logic                    credit_avail,
    input  wire logic                    tag_free,
    input  wire logic [tl_pkg::TAG_W-1:0] alloc_tag,
    input  wire logic                    wr_resp_ready,
    output logic                         wr_pop,
    output logic                         rd_pop,
    output logic                         consume,
    output logic                         alloc,
    output logic [tl_pkg::ID_W-1:0]      alloc_id,
    output logic                         tlp_tx_valid,
    output tl_pkg::tlp_t                 tlp_tx,
    output logic                         wr_resp_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WR_RESP
    } state_t;

    state_t       state;
    logic         go_wr;
    logic         go_rd;
    logic         issue_wr;
    tl_pkg::tlp_t next_tlp;

    // ----------------------------------------------------------------------
    // Arbitration
    // ----------------------------------------------------------------------
    always_comb begin
        go_wr = 1'b0;
        go_rd = 1'b0;
        if (state == ST_IDLE && credit_avail) begin
            if (!wr_empty) begin
                go_wr = 1'b1;
            end else if (!rd_empty && tag_free) begin
                // Reads also need a tag
                go_rd = 1'b1;
            end
        end
    end

    assign wr_pop   = go_wr;
    assign rd_pop   = go_rd;
    assign consume  = go_wr || go_rd;
    assign alloc    = go_rd;
    assign alloc_id = rd_head.id;

    // ----------------------------------------------------------------------
    // Header build
    // ----------------------------------------------------------------------
    always_comb begin
        next_tlp                 = '0;
        next_tlp.hdr.length      = 10'd1;
        next_tlp.hdr.status      = tl_pkg::CPL_SC;
        if (go_wr) begin
            next_tlp.hdr.fmt_type = tl_pkg::TLP_MWR32;
            next_tlp.hdr.first_be = wr_head.strb;
            next_tlp.hdr.addr     = wr_head.addr;
            next_tlp.data         = wr_head.data;
        end else begin
            next_tlp.hdr.fmt_type = tl_pkg::TLP_MRD32;
            next_tlp.hdr.tag      = 8'(alloc_tag);
            next_tlp.hdr.first_be = '1;
            next_tlp.hdr.addr     = rd_head.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (consume) begin
            tlp_tx <= next_tlp;
        end
    end

    // ----------------------------------------------------------------------
    // State
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            issue_wr <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (consume) begin
                        state    <= ST_ISSUE;
                        issue_wr <= go_wr;
                    end
                end
                ST_ISSUE: begin
                    // Posted writes still owe the AXI side a response
                    state <= issue_wr ? ST_WR_RESP : ST_IDLE;
                end
                ST_WR_RESP: begin
                    if (wr_resp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // One cycle strobe toward the link layer
    assign tlp_tx_valid  = (state == ST_ISSUE);
    assign wr_resp_valid = (state == ST_WR_RESP);

endmodule

`default_nettype wire

// ==== testbench/tb_tl_top.sv ====
// Testbench for the transaction layer request path
// Random AXI traffic, a link layer model with credits and completions, assertion checks
`default_nettype none

module tb_tl_top;

    localparam int N_MIX_WR       = 12;
    localparam int N_MIX_RD       = 24;
    localparam int N_TAG_RD       = 20;
    localparam int N_CRED_WR      = 12;
    localparam int TOTAL_REQS     = N_MIX_WR + N_MIX_RD + N_TAG_RD + N_CRED_WR;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_REQS + 500;

    localparam logic [31:0] LFSR_SEED     = 32'h45a7_ce81;
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;
    localparam logic [31:0] CPL_DATA_MASK = 32'hA5A5_5A5A;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              wr_req_valid;
    logic              wr_req_ready;
    tl_pkg::wr_req_t   wr_req;
    logic              wr_resp_valid;
    logic              wr_resp_ready;
    logic              rd_req_valid;
    logic              rd_req_ready;
    tl_pkg::rd_req_t   rd_req;
    logic              rd_resp_valid;
    logic              rd_resp_ready;
    tl_pkg::rd_resp_t  rd_resp;
    logic              tlp_tx_valid;
    tl_pkg::tlp_t      tlp_tx;
    logic              credit_return;
    logic              cpl_valid;
    tl_pkg::tlp_t      cpl;

    logic [31:0]       lfsr = LFSR_SEED;
    int                errors = 0;
    int                cycles = 0;
    logic              timed_out = 1'b0;
    logic              withhold = 1'b0;
    logic              rd_stall = 1'b0;

    // Scoreboards
    tl_pkg::wr_req_t   exp_wr[$];
    tl_pkg::rd_req_t   exp_rd[$];
    int                cpl_order[$];
    logic [tl_pkg::TAG_COUNT-1:0] tag_busy = '0;
    logic [3:0]        out_id [tl_pkg::TAG_COUNT];
    logic [31:0]       out_addr [tl_pkg::TAG_COUNT];
    int                rd_outstanding = 0;
    int                wr_pending = 0;
    int                n_writes = 0;
    int                n_reads = 0;
    int                tlp_count = 0;
    int                ret_count = 0;

    // Link layer state
    logic [3:0]        pend_tag[$];
    logic [31:0]       pend_addr[$];
    int                pend_wait[$];
    int                link_held = 0;

    always #2 clk = ~clk;

    tl_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_req_valid  (wr_req_valid),
        .wr_req_ready  (wr_req_ready),
        .wr_req        (wr_req),
        .wr_resp_valid (wr_resp_valid),
        .wr_resp_ready (wr_resp_ready),
        .rd_req_valid  (rd_req_valid),
        .rd_req_ready  (rd_req_ready),
        .rd_req        (rd_req),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_ready (rd_resp_ready),
        .rd_resp       (rd_resp),
        .tlp_tx_valid  (tlp_tx_valid),
        .tlp_tx        (tlp_tx),
        .credit_return (credit_return),
        .cpl_valid     (cpl_valid),
        .cpl           (cpl)
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    // Galois LFSR stepped once for each bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
        end
        return r;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic end_run();
        $display("Summary: %0d writes, %0d reads, %0d TLPs, %0d credit returns, %0d errors",
                 n_writes, n_reads, tlp_count, ret_count, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic send_writes(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            while (rand_bits(2) == 0) begin
                wr_req_valid = 1'b0;
                @(negedge clk);
            end
            wr_req_valid = 1'b1;
            wr_req.addr  = rand_bits(32);
            wr_req.data  = rand_bits(32);
            wr_req.strb  = rand_bits(4);
            while (!wr_req_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        @(negedge clk);
        wr_req_valid = 1'b0;
    endtask

    task automatic send_reads(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            while (rand_bits(2) == 0) begin
                rd_req_valid = 1'b0;
                @(negedge clk);
            end
            rd_req_valid = 1'b1;
            rd_req.id    = rand_bits(4);
            rd_req.addr  = rand_bits(32);
            while (!rd_req_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        @(negedge clk);
        rd_req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_wr.size() != 0 || exp_rd.size() != 0 || rd_outstanding != 0 ||
               wr_pending != 0 || pend_tag.size() != 0 || link_held != 0) begin
            @(negedge clk);
        end
    endtask

    // ----------------------------------------------------------------------
    // Link layer model
    // ----------------------------------------------------------------------
    task automatic drive_link();
        int           start;
        int           pick;
        int           k;
        int           j;
        tl_pkg::tlp_t c;
        cpl_valid     = 1'b0;
        credit_return = 1'b0;
        pick          = -1;
        for (k = 0; k < pend_wait.size(); k++) begin
            if (pend_wait[k] > 0) begin
                pend_wait[k]--;
            end
        end
        // Random starting point gives out of order completions
        if (pend_tag.size() != 0) begin
            start = rand_bits(4) % pend_tag.size();
            for (k = 0; k < pend_tag.size(); k++) begin
                j = (start + k) % pend_tag.size();
                if (pick < 0 && pend_wait[j] == 0) begin
                    pick = j;
                end
            end
        end
        if (pick >= 0) begin
            c              = '0;
            c.hdr.fmt_type = tl_pkg::TLP_CPLD;
            c.hdr.length   = 10'd1;
            c.hdr.tag      = 8'(pend_tag[pick]);
            c.hdr.first_be = '1;
            c.hdr.status   = pend_addr[pick][2] ? tl_pkg::CPL_UR : tl_pkg::CPL_SC;
            c.hdr.addr     = pend_addr[pick];
            c.data         = pend_addr[pick] ^ CPL_DATA_MASK;
            cpl            = c;
            cpl_valid      = 1'b1;
            pend_tag.delete(pick);
            pend_addr.delete(pick);
            pend_wait.delete(pick);
        end
        if (!withhold && link_held > 0 && rand_bits(2) == 0) begin
            credit_return = 1'b1;
            link_held--;
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            wr_resp_ready = 1'b0;
            rd_resp_ready = 1'b0;
            cpl_valid     = 1'b0;
            credit_return = 1'b0;
        end else begin
            wr_resp_ready = (rand_bits(2) != 0);
            rd_resp_ready = !rd_stall && (rand_bits(2) != 0);
            drive_link();
        end
    end

    // ----------------------------------------------------------------------
    // Monitor and scoreboards
    // ----------------------------------------------------------------------
    always @(posedge clk) begin : monitor
        tl_pkg::wr_req_t wexp;
        tl_pkg::rd_req_t rexp;
        int              t;
        if (rst_n) begin
            if (wr_req_valid && wr_req_ready) begin
                exp_wr.push_back(wr_req);
                n_writes++;
            end
            if (rd_req_valid && rd_req_ready) begin
                exp_rd.push_back(rd_req);
                n_reads++;
            end
            if (credit_return) begin
                ret_count++;
            end
            if (cpl_valid) begin
                cpl_order.push_back(int'(cpl.hdr.tag[3:0]));
            end
            if (wr_resp_valid && wr_resp_ready) begin
                if (wr_pending == 0) begin
                    report_failure("write response with no MWr waiting for it");
                end else begin
                    wr_pending--;
                end
            end
            if (rd_resp_valid && rd_resp_ready) begin
                if (cpl_order.size() == 0) begin
                    report_failure("read response with no completion behind it");
                end else begin
                    t = cpl_order.pop_front();
                    check_equal("rd_resp id", 32'(out_id[t]), 32'(rd_resp.id));
                    check_equal("rd_resp data", out_addr[t] ^ CPL_DATA_MASK, rd_resp.data);
                    check_equal("rd_resp resp", out_addr[t][2] ? 32'd2 : 32'd0,
                                32'(rd_resp.resp));
                    tag_busy[t] = 1'b0;
                    rd_outstanding--;
                end
            end
            if (tlp_tx_valid) begin
                tlp_count++;
                link_held++;
                check_equal("tlp length", 32'd1, 32'(tlp_tx.hdr.length));
                check_equal("tlp status", 32'd0, 32'(tlp_tx.hdr.status));
                if (tlp_tx.hdr.fmt_type == tl_pkg::TLP_MWR32) begin
                    if (exp_wr.size() == 0) begin
                        report_failure("MWr sent with no accepted write waiting");
                    end else begin
                        wexp = exp_wr.pop_front();
                        check_equal("mwr addr", wexp.addr, tlp_tx.hdr.addr);
                        check_equal("mwr data", wexp.data, tlp_tx.data);
                        check_equal("mwr first_be", 32'(wexp.strb), 32'(tlp_tx.hdr.first_be));
                        wr_pending++;
                    end
                end else if (tlp_tx.hdr.fmt_type == tl_pkg::TLP_MRD32) begin
                    if (exp_rd.size() == 0) begin
                        report_failure("MRd sent with no accepted read waiting");
                    end else begin
                        rexp = exp_rd.pop_front();
                        t    = int'(tlp_tx.hdr.tag[3:0]);
                        check_equal("mrd addr", rexp.addr, tlp_tx.hdr.addr);
                        check_equal("mrd data", 32'd0, tlp_tx.data);
                        check_equal("mrd tag upper bits", 32'd0, 32'(tlp_tx.hdr.tag[7:4]));
                        out_id[t]   = rexp.id;
                        out_addr[t] = rexp.addr;
                        tag_busy[t] = 1'b1;
                        rd_outstanding++;
                        pend_tag.push_back(tlp_tx.hdr.tag[3:0]);
                        pend_addr.push_back(tlp_tx.hdr.addr);
                        pend_wait.push_back(2 + int'(rand_bits(4)));
                    end
                end else begin
                    report_failure("TLP with an unknown format/type code");
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Protocol checks
    // ----------------------------------------------------------------------
    a_reset_idle : assert property (@(posedge clk) $rose(rst_n) |->
        !tlp_tx_valid && !wr_resp_valid && !rd_resp_valid && wr_req_ready && rd_req_ready)
        else report_failure("outputs not idle when reset was released");

    a_credit_bound : assert property (@(posedge clk) disable iff (!rst_n)
        tlp_tx_valid |-> tlp_count < tl_pkg::CREDIT_MAX + ret_count)
        else report_failure("TLP sent beyond the credits granted");

    a_withhold_silent : assert property (@(posedge clk) disable iff (!rst_n)
        (withhold && link_held == tl_pkg::CREDIT_MAX) |-> !tlp_tx_valid)
        else report_failure("TLP sent while all credits were withheld");

    a_tag_unique : assert property (@(posedge clk) disable iff (!rst_n)
        (tlp_tx_valid && tlp_tx.hdr.fmt_type == tl_pkg::TLP_MRD32) |->
        !tag_busy[tlp_tx.hdr.tag[3:0]])
        else report_failure("read tag reused while still outstanding");

    a_tag_limit : assert property (@(posedge clk) disable iff (!rst_n)
        (tlp_tx_valid && tlp_tx.hdr.fmt_type == tl_pkg::TLP_MRD32) |->
        rd_outstanding < tl_pkg::TAG_COUNT)
        else report_failure("MRd sent with every tag outstanding");

    a_rd_resp_hold : assert property (@(posedge clk) disable iff (!rst_n)
        (rd_resp_valid && !rd_resp_ready) |=> rd_resp_valid && $stable(rd_resp))
        else report_failure("read response dropped or changed while stalled");

    a_wr_resp_hold : assert property (@(posedge clk) disable iff (!rst_n)
        (wr_resp_valid && !wr_resp_ready) |=> wr_resp_valid)
        else report_failure("write response dropped while stalled");

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin : stimulus
        int tlp_mark;
        rst_n         = 1'b0;
        wr_req_valid  = 1'b0;
        wr_req        = '0;
        wr_resp_ready = 1'b0;
        rd_req_valid  = 1'b0;
        rd_req        = '0;
        rd_resp_ready = 1'b0;
        credit_return = 1'b0;
        cpl_valid     = 1'b0;
        cpl           = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Mixed writes and reads
        fork
            send_writes(N_MIX_WR);
            send_reads(N_MIX_RD);
        join
        wait_drain();

        // Fill the tag pool while read responses are held off
        @(negedge clk);
        rd_stall = 1'b1;
        send_reads(N_TAG_RD);
        while (rd_outstanding < tl_pkg::TAG_COUNT) begin
            @(negedge clk);
        end
        repeat (30) @(negedge clk);
        rd_stall = 1'b0;
        wait_drain();

        // Withhold credits until the pool is empty
        @(negedge clk);
        withhold = 1'b1;
        fork
            send_writes(N_CRED_WR);
            begin
                while (link_held < tl_pkg::CREDIT_MAX) begin
                    @(negedge clk);
                end
                tlp_mark = tlp_count;
                repeat (20) @(negedge clk);
                check_equal("tlps while withheld", 32'(tlp_mark), 32'(tlp_count));
                withhold = 1'b0;
                while (tlp_count == tlp_mark) begin
                    @(negedge clk);
                end
            end
        join
        wait_drain();

        repeat (10) @(negedge clk);
        end_run();
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        timed_out = 1'b1;
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end_run();
    end

endmodule

`default_nettype wire
